// ==== hw/spi_cmd_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types for the SPI command link
//////////////////////////////////////////////////////////////////////

package spi_cmd_pkg;

  // Width of the byte position within one message
  // Counts 0..15 and then holds at 15
  localparam int IDX_W = 4;

  //////////////////////////////////////////////////////////////////////
  // Byte word handed from the sck domain to the clk domain
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    // Received byte, MSB first on the wire
    logic [7:0]       data;
    // Position in the message, 0 is the command byte
    logic [IDX_W-1:0] idx;
    // Set for the command byte
    logic             first;
  } spi_byte_t;

  //////////////////////////////////////////////////////////////////////
  // Command byte encodings
  //////////////////////////////////////////////////////////////////////

  // Any other code is accepted and does nothing
  typedef enum logic [7:0] {
    // WRITE addr data
    CMD_WRITE = 8'h01,
    // READ addr, response on the next byte
    CMD_READ  = 8'h02,
    // Zero the register file and the response
    CMD_CLEAR = 8'h03
  } cmd_code_e;

endpackage

// ==== hw/spi_byte_rx.sv ====
`timescale 1ns/10ps

module spi_byte_rx
  import spi_cmd_pkg::*;
(
  input  logic       sck,
  input  logic       rst_n,
  input  logic       mosi,
  input  logic       ssel,
  input  logic       full,
  input  logic [7:0] tx_data,
  output logic       miso,
  output logic       miso_en,
  output logic       wr_en,
  output spi_byte_t  wr_data
);

  // Low while reset is held or the slave is deselected
  logic             msg_clr_n;

  // Bit position inside the current byte
  logic [2:0]       bit_cnt;
  // Byte position inside the current message
  logic [IDX_W-1:0] byte_idx;

  // First seven bits of the incoming byte
  logic [6:0]       rx_shift;
  // Remaining response bits after the MSB
  logic [6:0]       tx_shift;

  // Rising sck edge that carries bit 7
  logic             byte_done;

  //////////////////////////////////////////////////////////////////////
  // Bit and byte counters
  //////////////////////////////////////////////////////////////////////

  // ssel high restarts the message without an sck edge
  assign msg_clr_n = rst_n & ~ssel;

  always_ff @(posedge sck or negedge msg_clr_n) begin
    if (!msg_clr_n) begin
      bit_cnt  <= 3'd0;
      byte_idx <= '0;
    end else begin
      // Wraps from 7 back to 0 at each byte
      bit_cnt <= bit_cnt + 3'd1;
      // Saturating index
      if (bit_cnt == 3'd7 && byte_idx != '1) begin
        byte_idx <= byte_idx + IDX_W'(1);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Receive path
  //////////////////////////////////////////////////////////////////////

  // Sampled on the rising edge, MSB first
  always_ff @(posedge sck) begin
    rx_shift <= {rx_shift[5:0], mosi};
  end

  assign byte_done = ~ssel & (bit_cnt == 3'd7);

  // FIFO takes the word on the same edge that samples bit 7
  // so the last byte of a message needs no further sck edge
  assign wr_en = byte_done & ~full;

  always_comb begin
    wr_data.data  = {rx_shift, mosi};
    wr_data.idx   = byte_idx;
    wr_data.first = (byte_idx == '0);
  end

  //////////////////////////////////////////////////////////////////////
  // Transmit path
  //////////////////////////////////////////////////////////////////////

  // Load the response on the first edge of each byte
  // then move one bit per rising edge
  always_ff @(posedge sck) begin
    if (bit_cnt == 3'd0) begin
      tx_shift <= tx_data[6:0];
    end else begin
      tx_shift <= {tx_shift[5:0], 1'b0};
    end
  end

  assign miso_en = ~ssel;

  // MSB comes straight from the response register before the first edge
  assign miso = miso_en & ((bit_cnt == 3'd0) ? tx_data[7] : tx_shift[6]);

  // Host pacing and FIFO depth together keep every byte
  a_no_drop: assert property (
    @(posedge sck) disable iff (!rst_n)
    byte_done |-> !full
  ) else $error("spi_byte_rx: byte dropped, FIFO full");

endmodule

// ==== hw/spi_byte_fifo.sv ====
`timescale 1ns/10ps

module spi_byte_fifo #(
  parameter type payload_t  = logic [7:0],
  parameter int  FIFO_DEPTH = 8
) (
  input  logic     rst_n,
  // Write port
  input  logic     wr_clk,
  input  logic     wr_en,
  input  payload_t wr_data,
  output logic     full,
  // Read port, first word falls through
  input  logic     rd_clk,
  input  logic     rd_en,
  output payload_t rd_data,
  output logic     empty
);

  localparam int AW = $clog2(FIFO_DEPTH);

  // Gray write pointer equals the read pointer with the top two bits flipped when full
  localparam logic [AW:0] LAP_MASK = (AW + 1)'(3 << (AW - 1));

  payload_t mem [FIFO_DEPTH];

  // Write domain pointers
  logic [AW:0] wr_bin;
  logic [AW:0] wr_bin_next;
  logic [AW:0] wr_gray;
  logic [AW:0] wr_gray_next;
  // Read pointer seen in the write domain
  logic [AW:0] rd_gray_w1;
  logic [AW:0] rd_gray_w2;

  // Read domain pointers
  logic [AW:0] rd_bin;
  logic [AW:0] rd_bin_next;
  logic [AW:0] rd_gray;
  logic [AW:0] rd_gray_next;
  // Write pointer seen in the read domain
  logic [AW:0] wr_gray_r1;
  logic [AW:0] wr_gray_r2;

  //////////////////////////////////////////////////////////////////////
  // Write domain
  //////////////////////////////////////////////////////////////////////

  assign wr_bin_next  = wr_bin + (AW + 1)'(wr_en & ~full);
  assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
      full       <= 1'b0;
    end else begin
      wr_bin     <= wr_bin_next;
      wr_gray    <= wr_gray_next;
      // Two-flop pointer sync
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
      full       <= (wr_gray_next == (rd_gray_w2 ^ LAP_MASK));
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_en && !full) begin
      mem[wr_bin[AW-1:0]] <= wr_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read domain
  //////////////////////////////////////////////////////////////////////

  assign rd_bin_next  = rd_bin + (AW + 1)'(rd_en & ~empty);
  assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
      empty      <= 1'b1;
    end else begin
      rd_bin     <= rd_bin_next;
      rd_gray    <= rd_gray_next;
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
      empty      <= (rd_gray_next == wr_gray_r2);
    end
  end

  // Head entry, valid while empty is low
  assign rd_data = mem[rd_bin[AW-1:0]];

  a_no_underflow: assert property (
    @(posedge rd_clk) disable iff (!rst_n) rd_en |-> !empty
  ) else $error("spi_byte_fifo: read while empty");

  a_no_overflow: assert property (
    @(posedge wr_clk) disable iff (!rst_n) wr_en |-> !full
  ) else $error("spi_byte_fifo: write while full");

endmodule

// ==== hw/spi_cmd_exec.sv ====
`timescale 1ns/10ps

module spi_cmd_exec
  import spi_cmd_pkg::*;
#(
  parameter int REG_COUNT = 16
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       empty,
  input  spi_byte_t  rd_data,
  output logic       rd_en,
  output logic [7:0] tx_data,
  output logic       cmd_ready,
  output logic       param_ready,
  output logic [7:0] cmd_data,
  output logic [7:0] param_data
);

  localparam int RA_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

  // Popped byte, one cycle after the FIFO read
  logic            pop_q;
  spi_byte_t       byte_q;

  // Command of the message in progress
  cmd_code_e       cur_cmd;
  // Address from the WRITE index-1 byte
  logic [RA_W-1:0] addr_q;
  // Popped data folded into the register range
  logic [RA_W-1:0] byte_addr;

  logic [7:0]      regs [REG_COUNT];

  //////////////////////////////////////////////////////////////////////
  // FIFO pop, one byte per cycle
  //////////////////////////////////////////////////////////////////////

  assign rd_en = ~empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pop_q <= 1'b0;
    end else begin
      pop_q <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      byte_q <= rd_data;
    end
  end

  assign byte_addr = RA_W'(byte_q.data % REG_COUNT);

  //////////////////////////////////////////////////////////////////////
  // Ready strobes with their data
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_ready   <= 1'b0;
      param_ready <= 1'b0;
      cmd_data    <= 8'h00;
      param_data  <= 8'h00;
    end else begin
      cmd_ready   <= pop_q & byte_q.first;
      param_ready <= pop_q & ~byte_q.first;
      // Data holds until the next byte of the same kind
      if (pop_q && byte_q.first) begin
        cmd_data <= byte_q.data;
      end
      if (pop_q && !byte_q.first) begin
        param_data <= byte_q.data;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Command execution
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_cmd <= cmd_code_e'(8'h00);
      addr_q  <= '0;
      tx_data <= 8'h00;
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= 8'h00;
      end
    end else if (pop_q) begin
      if (byte_q.first) begin
        cur_cmd <= cmd_code_e'(byte_q.data);
        // CLEAR acts on the command byte itself
        if (byte_q.data == CMD_CLEAR) begin
          tx_data <= 8'h00;
          for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= 8'h00;
          end
        end
      end else begin
        case (cur_cmd)
          CMD_WRITE: begin
            if (byte_q.idx == IDX_W'(1)) begin
              addr_q <= byte_addr;
            end else if (byte_q.idx == IDX_W'(2)) begin
              regs[addr_q] <= byte_q.data;
            end
          end
          CMD_READ: begin
            // Shifted out on the following byte
            if (byte_q.idx == IDX_W'(1)) begin
              tx_data <= regs[byte_addr];
            end
          end
          // Unknown codes and extra parameters
          default: begin
          end
        endcase
      end
    end
  end

  // Head word is fully written by the time it is popped
  a_pop_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_en |-> !$isunknown(rd_data)
  ) else $error("spi_cmd_exec: pop of unsettled FIFO word");

  // Command flag agrees with the index across the crossing
  a_first_idx: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_en |-> (rd_data.first == (rd_data.idx == '0))
  ) else $error("spi_cmd_exec: first flag and index disagree");

endmodule

// ==== hw/spi_cmd_link_top.sv ====
`timescale 1ns/10ps

module spi_cmd_link_top
  import spi_cmd_pkg::*;
#(
  parameter int FIFO_DEPTH = 8,
  parameter int REG_COUNT  = 16
) (
  input  logic       clk,
  input  logic       rst_n,
  // SPI pins
  input  logic       sck,
  input  logic       mosi,
  input  logic       ssel,
  output logic       miso,
  output logic       miso_en,
  // clk domain outputs
  output logic       cmd_ready,
  output logic       param_ready,
  output logic [7:0] cmd_data,
  output logic [7:0] param_data
);

  // sck domain side of the FIFO
  logic       wr_en;
  spi_byte_t  wr_data;
  logic       full;

  // clk domain side of the FIFO
  logic       rd_en;
  spi_byte_t  rd_data;
  logic       empty;

  // Response byte back to the shifter
  logic [7:0] tx_data;

  spi_byte_rx u_rx (
    .sck     (sck),
    .rst_n   (rst_n),
    .mosi    (mosi),
    .ssel    (ssel),
    .full    (full),
    .tx_data (tx_data),
    .miso    (miso),
    .miso_en (miso_en),
    .wr_en   (wr_en),
    .wr_data (wr_data)
  );

  spi_byte_fifo #(
    .payload_t  (spi_byte_t),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .rst_n   (rst_n),
    .wr_clk  (sck),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .full    (full),
    .rd_clk  (clk),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .empty   (empty)
  );

  spi_cmd_exec #(
    .REG_COUNT (REG_COUNT)
  ) u_exec (
    .clk         (clk),
    .rst_n       (rst_n),
    .empty       (empty),
    .rd_data     (rd_data),
    .rd_en       (rd_en),
    .tx_data     (tx_data),
    .cmd_ready   (cmd_ready),
    .param_ready (param_ready),
    .cmd_data    (cmd_data),
    .param_data  (param_data)
  );

endmodule

// ==== dv/spi_cmd_link_tb.sv ====
`timescale 1ns/10ps

module spi_cmd_link_tb
  import spi_cmd_pkg::*;
();

  localparam int FIFO_DEPTH     = 8;
  localparam int REG_COUNT      = 16;
  localparam int RA_W           = $clog2(REG_COUNT);
  localparam int IDX_MAX        = (1 << IDX_W) - 1;
  // About 175 bytes at roughly 81 clk each, plus reset, doubled
  localparam int TIMEOUT_CYCLES = 40000;
  // Last sck edge to strobe is about 5 clk
  localparam int STROBE_WAIT    = 100;

  logic       clk;
  logic       rst_n;
  logic       sck;
  logic       mosi;
  logic       ssel;
  logic       miso;
  logic       miso_en;
  logic       cmd_ready;
  logic       param_ready;
  logic [7:0] cmd_data;
  logic [7:0] param_data;

  // Fibonacci LFSR state
  logic [31:0] lfsr_state;

  // Reference model of the register file and the response register
  logic [7:0]      ref_regs [REG_COUNT];
  logic [7:0]      ref_tx;
  logic [7:0]      ref_cmd;
  logic [RA_W-1:0] ref_addr;

  // Outgoing message and the bytes seen on miso
  logic [7:0] msg_q [$];
  logic [7:0] resp_q [$];
  // Addresses written by the read-back test
  logic [7:0] addr_list [$];

  // Strobes collected by the monitor
  spi_byte_t        strobe_q [$];
  logic [IDX_W-1:0] mon_idx = '0;

  int cycle_cnt = 0;

  spi_cmd_link_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .REG_COUNT  (REG_COUNT)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck         (sck),
    .mosi        (mosi),
    .ssel        (ssel),
    .miso        (miso),
    .miso_en     (miso_en),
    .cmd_ready   (cmd_ready),
    .param_ready (param_ready),
    .cmd_data    (cmd_data),
    .param_data  (param_data)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compares
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_failure();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAIL %0d ns: %s", $time, msg);
    stop_on_failure();
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    stop_on_failure();
  endtask

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %02h expected %02h", what, got, exp));
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %0b expected %0b", what, got, exp));
    end
  endtask

  task automatic check_strobe(input spi_byte_t got, input spi_byte_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("strobe first=%0b idx=%0d data=%02h, expected %0b/%0d/%02h",
                                got.first, got.idx, got.data, exp.first, exp.idx, exp.data));
    end
  endtask

  // Timeout guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_error($sformatf("run did not finish within %0d clk cycles", TIMEOUT_CYCLES));
    end
  end

  // Strobe monitor, sampled mid cycle
  always @(negedge clk) begin
    spi_byte_t s;
    check_level("miso_en against ssel", miso_en, !ssel);
    if (cmd_ready) begin
      mon_idx = '0;
      s.data  = cmd_data;
      s.idx   = mon_idx;
      s.first = 1'b1;
      strobe_q.push_back(s);
    end
    if (param_ready) begin
      // Same saturation as the byte index
      if (mon_idx != IDX_W'(IDX_MAX)) begin
        mon_idx = mon_idx + IDX_W'(1);
      end
      s.data  = param_data;
      s.idx   = mon_idx;
      s.first = 1'b0;
      strobe_q.push_back(s);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = 8'h00;
    for (int k = 0; k < 8; k++) begin
      b = {b[6:0], lfsr_next_bit()};
    end
    return b;
  endfunction

  // Address wraps modulo the register count
  function automatic logic [RA_W-1:0] reg_index(input logic [7:0] b);
    return RA_W'(b % REG_COUNT);
  endfunction

  function automatic void model_step(input int idx, input logic [7:0] b);
    if (idx == 0) begin
      ref_cmd = b;
      if (b == CMD_CLEAR) begin
        ref_regs = '{default: 8'h00};
        ref_tx   = 8'h00;
      end
    end else if (idx == 1) begin
      if (ref_cmd == CMD_WRITE) begin
        ref_addr = reg_index(b);
      end else if (ref_cmd == CMD_READ) begin
        ref_tx = ref_regs[reg_index(b)];
      end
    end else if (idx == 2 && ref_cmd == CMD_WRITE) begin
      ref_regs[ref_addr] = b;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // SPI master
  //////////////////////////////////////////////////////////////////////

  // Mode 0, 4 clk per half period, MSB first
  task automatic spi_xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
    logic [7:0] sh;
    sh = tx;
    rx = 8'h00;
    for (int b = 0; b < 8; b++) begin
      @(posedge clk);
      sck  <= 1'b0;
      mosi <= sh[7];
      sh = {sh[6:0], 1'b0};
      repeat (3) @(posedge clk);
      // Just before the rising edge
      @(negedge clk);
      rx = {rx[6:0], miso};
      @(posedge clk);
      sck <= 1'b1;
      repeat (3) @(posedge clk);
    end
    @(posedge clk);
    sck <= 1'b0;
    // Idle gap between bytes
    repeat (16) @(posedge clk);
  endtask

  task automatic new_msg(input logic [7:0] cmd);
    msg_q.delete();
    msg_q.push_back(cmd);
  endtask

  // Sends msg_q, checks miso bytes and the strobe sequence
  task automatic send_msg();
    spi_byte_t  exp_s;
    spi_byte_t  got_s;
    logic [7:0] rx;
    int         n;
    int         waited;
    n = msg_q.size();
    resp_q.delete();
    @(posedge clk);
    ssel <= 1'b0;
    repeat (4) @(posedge clk);
    for (int i = 0; i < n; i++) begin
      spi_xfer_byte(msg_q[i], rx);
      resp_q.push_back(rx);
      // Response reflects every byte popped before this one
      check_byte($sformatf("miso byte %0d", i), rx, ref_tx);
      model_step(i, msg_q[i]);
    end
    @(posedge clk);
    ssel <= 1'b1;
    waited = 0;
    while (strobe_q.size() < n) begin
      @(posedge clk);
      waited++;
      if (waited > STROBE_WAIT) begin
        report_error($sformatf("only %0d of %0d strobes arrived", strobe_q.size(), n));
      end
    end
    // Deselect gap, long enough to catch stray strobes
    repeat (16) @(posedge clk);
    for (int i = 0; i < n; i++) begin
      got_s       = strobe_q.pop_front();
      exp_s.data  = msg_q[i];
      exp_s.idx   = IDX_W'((i > IDX_MAX) ? IDX_MAX : i);
      exp_s.first = (i == 0);
      check_strobe(got_s, exp_s);
    end
    if (strobe_q.size() != 0) begin
      report_error($sformatf("%0d extra strobes after the message", strobe_q.size()));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state_read();
    check_level("miso_en while deselected", miso_en, 1'b0);
    new_msg(CMD_READ);
    msg_q.push_back(rand_byte());
    msg_q.push_back(8'h00);
    send_msg();
    check_byte("READ after reset", resp_q[2], 8'h00);
  endtask

  task automatic strobe_order();
    new_msg(CMD_WRITE);
    for (int i = 0; i < 3; i++) begin
      msg_q.push_back(rand_byte());
    end
    send_msg();
  endtask

  task automatic write_read_back();
    logic [7:0] a;
    addr_list.delete();
    for (int i = 0; i < 8; i++) begin
      a = rand_byte();
      addr_list.push_back(a);
      new_msg(CMD_WRITE);
      msg_q.push_back(a);
      msg_q.push_back(rand_byte());
      send_msg();
    end
    foreach (addr_list[i]) begin
      new_msg(CMD_READ);
      msg_q.push_back(addr_list[i]);
      msg_q.push_back(8'h00);
      send_msg();
      check_byte("READ back", resp_q[2], ref_regs[reg_index(addr_list[i])]);
    end
  endtask

  task automatic clear_regs();
    new_msg(CMD_CLEAR);
    send_msg();
    foreach (addr_list[i]) begin
      new_msg(CMD_READ);
      msg_q.push_back(addr_list[i]);
      msg_q.push_back(8'h00);
      send_msg();
      check_byte("READ after CLEAR", resp_q[2], 8'h00);
    end
  endtask

  task automatic unknown_and_extra();
    // Give the registers something to lose
    for (int i = 0; i < 4; i++) begin
      new_msg(CMD_WRITE);
      msg_q.push_back(rand_byte());
      msg_q.push_back(rand_byte());
      send_msg();
    end
    new_msg(8'h00);
    msg_q.push_back(rand_byte());
    msg_q.push_back(rand_byte());
    send_msg();
    new_msg(8'hc4);
    for (int i = 0; i < 3; i++) begin
      msg_q.push_back(rand_byte());
    end
    send_msg();
    // Long message, index saturates at 15
    new_msg(8'hff);
    for (int i = 0; i < 17; i++) begin
      msg_q.push_back(rand_byte());
    end
    send_msg();
    // Defined commands with trailing parameters
    new_msg(CMD_WRITE);
    for (int i = 0; i < 5; i++) begin
      msg_q.push_back(rand_byte());
    end
    send_msg();
    new_msg(CMD_READ);
    for (int i = 0; i < 3; i++) begin
      msg_q.push_back(rand_byte());
    end
    send_msg();
    for (int i = 0; i < REG_COUNT; i++) begin
      new_msg(CMD_READ);
      msg_q.push_back(8'(i));
      msg_q.push_back(8'h00);
      send_msg();
      check_byte($sformatf("register %0d", i), resp_q[2], ref_regs[RA_W'(i)]);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n <= 1'b0;
    sck   <= 1'b0;
    mosi  <= 1'b0;
    ssel  <= 1'b1;
    lfsr_state = 32'hdce5_56b7;
    ref_regs   = '{default: 8'h00};
    ref_tx     = 8'h00;
    ref_cmd    = 8'h00;
    ref_addr   = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    reset_state_read();
    strobe_order();
    write_read_back();
    clear_regs();
    unknown_and_extra();
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== spi_cmd_link.f ====
hw/spi_cmd_pkg.sv
hw/spi_byte_rx.sv
hw/spi_byte_fifo.sv
hw/spi_cmd_exec.sv
hw/spi_cmd_link_top.sv
dv/spi_cmd_link_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module spi_cmd_link_tb \
  -f spi_cmd_link.f

sim_out="$(./obj_dir/Vspi_cmd_link_tb 2>&1 || true)"
echo "$sim_out"

if grep -q "^All checks passed$" <<< "$sim_out"; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail"
  exit 1
fi
